/* verilog/rv_core_pkg.sv */
// rv_core_pkg: shared widths, encoding constants and operation codes for the integer core
package rv_core_pkg;

  localparam int XLEN     = 64;
  localparam int ILEN     = 32;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = $clog2(NUM_REGS);

  typedef logic [XLEN-1:0]   xlen_t;     // register values and results
  typedef logic [XLEN-1:0]   addr_t;     // program counter
  typedef logic [ILEN-1:0]   inst_t;     // raw instruction word
  typedef logic [REG_AW-1:0] reg_idx_t;  // register index

  localparam reg_idx_t REG_ZERO = '0;  // x0, hardwired zero

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;  // decoded for its offset only
  localparam logic [6:0] OPC_STORE     = 7'b0100011;  // decoded for its offset only

  // funct3 values
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_JALR    = 3'b000;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // funct7 and the rv64 shift-immediate upper field
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub
  localparam logic [5:0] F6_SRA  = 6'b010000;   // srai, inst[31:26]

  // operation carried from decode to execute
  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_SLTU,
    OP_AND,
    OP_XOR,
    OP_ADDW,
    OP_SLLW,
    OP_SRA,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BEQ,
    OP_BNE,
    OP_ILLEGAL
  } op_e;

endpackage

/* verilog/reg_file.sv */
// reg_file: 32 x 64-bit integer registers, two async read ports, one write port, x0 reads zero
`timescale 1ns/10ps

module reg_file (
  input  logic                  clk,
  input  rv_core_pkg::reg_idx_t rs1_idx,
  input  rv_core_pkg::reg_idx_t rs2_idx,
  output rv_core_pkg::xlen_t    rs1_val,
  output rv_core_pkg::xlen_t    rs2_val,
  input  logic                  wr_en,
  input  rv_core_pkg::reg_idx_t wr_idx,
  input  rv_core_pkg::xlen_t    wr_data
);

  import rv_core_pkg::*;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (wr_en && (wr_idx != REG_ZERO)) begin  // x0 writes dropped
      regs[wr_idx] <= wr_data;
    end
  end

  assign rs1_val = (rs1_idx == REG_ZERO) ? '0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == REG_ZERO) ? '0 : regs[rs2_idx];

endmodule

/* verilog/inst_decoder.sv */
// inst_decoder: accepts instruction words, stalls on hazards, decodes op and immediate, reads operands
`timescale 1ns/10ps

module inst_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  rv_core_pkg::addr_t    in_pc,
  input  rv_core_pkg::inst_t    in_inst,
  input  rv_core_pkg::reg_idx_t ex_stage_rd,
  input  rv_core_pkg::reg_idx_t ret_stage_rd,
  output rv_core_pkg::reg_idx_t rs1_idx,
  output rv_core_pkg::reg_idx_t rs2_idx,
  input  rv_core_pkg::xlen_t    rs1_val,
  input  rv_core_pkg::xlen_t    rs2_val,
  output logic                  dec_valid,
  input  logic                  dec_ready,
  output rv_core_pkg::op_e      dec_op,
  output rv_core_pkg::addr_t    dec_pc,
  output rv_core_pkg::reg_idx_t dec_rd,
  output rv_core_pkg::xlen_t    dec_rs1_val,
  output rv_core_pkg::xlen_t    dec_rs2_val,
  output rv_core_pkg::xlen_t    dec_imm
);

  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd_f;
  xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  op_e        op_c;
  xlen_t      imm_c;
  logic       use_rs1, use_rs2;
  logic       imm_op_b;   // immediate replaces rs2 as operand b
  logic       writes_rd;
  reg_idx_t   held_rd;
  logic       hazard_rs1, hazard_rs2;
  logic       stage_free, in_fire;

  assign opcode  = in_inst[6:0];
  assign funct3  = in_inst[14:12];
  assign funct7  = in_inst[31:25];
  assign rd_f    = in_inst[11:7];
  assign rs1_idx = in_inst[19:15];
  assign rs2_idx = in_inst[24:20];

  // all immediates sign-extend from inst[31]
  assign imm_i = {{52{in_inst[31]}}, in_inst[31:20]};
  assign imm_s = {{52{in_inst[31]}}, in_inst[31:25], in_inst[11:7]};
  assign imm_b = {{52{in_inst[31]}}, in_inst[7], in_inst[30:25], in_inst[11:8], 1'b0};
  assign imm_u = {{32{in_inst[31]}}, in_inst[31:12], 12'b0};
  assign imm_j = {{44{in_inst[31]}}, in_inst[19:12], in_inst[20], in_inst[30:21], 1'b0};

  always_comb begin
    op_c     = OP_ILLEGAL;
    imm_c    = imm_i;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    imm_op_b = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: op_c = OP_ADD;
          {F7_ALT,  F3_ADD_SUB}: op_c = OP_SUB;
          {F7_BASE, F3_SLTU}:    op_c = OP_SLTU;
          {F7_BASE, F3_AND}:     op_c = OP_AND;
          default:               op_c = OP_ILLEGAL;
        endcase
      end
      OPC_OP_32: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: op_c = OP_ADDW;
          {F7_BASE, F3_SLL}:     op_c = OP_SLLW;
          default:               op_c = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        use_rs1  = 1'b1;
        imm_op_b = 1'b1;
        case (funct3)
          F3_ADD_SUB: op_c = OP_ADD;   // addi
          F3_SLTU:    op_c = OP_SLTU;  // sltiu
          F3_XOR:     op_c = OP_XOR;   // xori
          F3_AND:     op_c = OP_AND;   // andi
          F3_SR:      op_c = (in_inst[31:26] == F6_SRA) ? OP_SRA : OP_ILLEGAL;
          default:    op_c = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM_32: begin
        use_rs1  = 1'b1;
        imm_op_b = 1'b1;
        op_c     = (funct3 == F3_ADD_SUB) ? OP_ADDW : OP_ILLEGAL;  // addiw
      end
      OPC_LUI: begin
        op_c  = OP_LUI;
        imm_c = imm_u;
      end
      OPC_AUIPC: begin
        op_c  = OP_AUIPC;
        imm_c = imm_u;
      end
      OPC_JAL: begin
        op_c  = OP_JAL;
        imm_c = imm_j;
      end
      OPC_JALR: begin
        use_rs1 = 1'b1;
        op_c    = (funct3 == F3_JALR) ? OP_JALR : OP_ILLEGAL;
      end
      OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm_c   = imm_b;
        case (funct3)
          F3_BEQ:  op_c = OP_BEQ;
          F3_BNE:  op_c = OP_BNE;
          default: op_c = OP_ILLEGAL;
        endcase
      end
      OPC_LOAD:  imm_c = imm_i;  // no data memory, retires illegal
      OPC_STORE: imm_c = imm_s;
      default:   op_c  = OP_ILLEGAL;
    endcase
    if (op_c == OP_ILLEGAL) begin  // an illegal word never stalls on its fields
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  assign writes_rd = !(op_c inside {OP_BEQ, OP_BNE, OP_ILLEGAL});

  // rd of every item still ahead of the regfile write
  assign held_rd    = dec_valid ? dec_rd : REG_ZERO;
  assign hazard_rs1 = use_rs1 && (rs1_idx != REG_ZERO) &&
                      ((rs1_idx == held_rd) || (rs1_idx == ex_stage_rd) ||
                       (rs1_idx == ret_stage_rd));
  assign hazard_rs2 = use_rs2 && (rs2_idx != REG_ZERO) &&
                      ((rs2_idx == held_rd) || (rs2_idx == ex_stage_rd) ||
                       (rs2_idx == ret_stage_rd));

  assign stage_free = !dec_valid || dec_ready;
  assign in_ready   = stage_free && !hazard_rs1 && !hazard_rs2;
  assign in_fire    = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (stage_free) begin
      dec_valid <= in_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      dec_op      <= op_c;
      dec_pc      <= in_pc;
      dec_rd      <= writes_rd ? rd_f : REG_ZERO;
      dec_rs1_val <= rs1_val;
      dec_rs2_val <= imm_op_b ? imm_c : rs2_val;
      dec_imm     <= imm_c;
    end
  end

  // a stalled item must not change under execute
  a_dec_op_stable: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_op));

endmodule

/* verilog/exec_unit.sv */
// exec_unit: ALU, word-op sign extension and branch/jump next-pc computation, one register stage
`timescale 1ns/10ps

module exec_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  dec_valid,
  output logic                  dec_ready,
  input  rv_core_pkg::op_e      dec_op,
  input  rv_core_pkg::addr_t    dec_pc,
  input  rv_core_pkg::reg_idx_t dec_rd,
  input  rv_core_pkg::xlen_t    dec_rs1_val,
  input  rv_core_pkg::xlen_t    dec_rs2_val,
  input  rv_core_pkg::xlen_t    dec_imm,
  output logic                  ex_valid,
  input  logic                  ex_ready,
  output rv_core_pkg::addr_t    ex_pc,
  output rv_core_pkg::reg_idx_t ex_rd,
  output rv_core_pkg::xlen_t    ex_value,
  output rv_core_pkg::addr_t    ex_next_pc,
  output logic                  ex_illegal,
  output rv_core_pkg::reg_idx_t ex_stage_rd
);

  import rv_core_pkg::*;

  logic        dec_fire;
  addr_t       pc_plus4;
  addr_t       branch_tgt;
  logic [31:0] add_w;
  logic [31:0] sll_w;
  logic        operands_eq;
  xlen_t       value_c;
  addr_t       next_pc_c;
  logic        illegal_c;

  assign dec_ready = !ex_valid || ex_ready;
  assign dec_fire  = dec_valid && dec_ready;

  assign pc_plus4    = dec_pc + addr_t'(4);
  assign branch_tgt  = dec_pc + dec_imm;  // also the jal target
  assign add_w       = dec_rs1_val[31:0] + dec_rs2_val[31:0];
  assign sll_w       = dec_rs1_val[31:0] << dec_rs2_val[4:0];
  assign operands_eq = (dec_rs1_val == dec_rs2_val);

  always_comb begin
    value_c   = '0;
    next_pc_c = pc_plus4;
    illegal_c = 1'b0;
    case (dec_op)
      OP_ADD:   value_c = dec_rs1_val + dec_rs2_val;
      OP_SUB:   value_c = dec_rs1_val - dec_rs2_val;
      OP_SLTU:  value_c = xlen_t'(dec_rs1_val < dec_rs2_val);
      OP_AND:   value_c = dec_rs1_val & dec_rs2_val;
      OP_XOR:   value_c = dec_rs1_val ^ dec_rs2_val;
      OP_SRA:   value_c = $signed(dec_rs1_val) >>> dec_imm[5:0];
      OP_ADDW:  value_c = {{32{add_w[31]}}, add_w};  // sign-extend low word
      OP_SLLW:  value_c = {{32{sll_w[31]}}, sll_w};
      OP_LUI:   value_c = dec_imm;
      OP_AUIPC: value_c = dec_pc + dec_imm;
      OP_JAL: begin
        value_c   = pc_plus4;  // link
        next_pc_c = branch_tgt;
      end
      OP_JALR: begin
        value_c   = pc_plus4;
        next_pc_c = (dec_rs1_val + dec_imm) & ~addr_t'(1);  // bit 0 cleared
      end
      OP_BEQ:   next_pc_c = operands_eq ? branch_tgt : pc_plus4;
      OP_BNE:   next_pc_c = operands_eq ? pc_plus4 : branch_tgt;
      default:  illegal_c = 1'b1;  // value stays 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (dec_ready) begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_fire) begin
      ex_pc      <= dec_pc;
      ex_rd      <= dec_rd;
      ex_value   <= value_c;
      ex_next_pc <= next_pc_c;
      ex_illegal <= illegal_c;
    end
  end

  assign ex_stage_rd = ex_valid ? ex_rd : REG_ZERO;  // hazard view for decode

endmodule

/* verilog/retire_stage.sv */
// retire_stage: holds the retire record, writes the register file on the output handshake
`timescale 1ns/10ps

module retire_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid,
  output logic                  ex_ready,
  input  rv_core_pkg::addr_t    ex_pc,
  input  rv_core_pkg::reg_idx_t ex_rd,
  input  rv_core_pkg::xlen_t    ex_value,
  input  rv_core_pkg::addr_t    ex_next_pc,
  input  logic                  ex_illegal,
  output logic                  out_valid,
  input  logic                  out_ready,
  output rv_core_pkg::addr_t    out_pc,
  output rv_core_pkg::reg_idx_t out_rd,
  output rv_core_pkg::xlen_t    out_value,
  output rv_core_pkg::addr_t    out_next_pc,
  output logic                  out_illegal,
  output logic                  wr_en,
  output rv_core_pkg::reg_idx_t wr_idx,
  output rv_core_pkg::xlen_t    wr_data,
  output rv_core_pkg::reg_idx_t ret_stage_rd
);

  import rv_core_pkg::*;

  assign ex_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (ex_ready) begin
      out_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && ex_ready) begin
      out_pc      <= ex_pc;
      out_rd      <= ex_rd;
      out_value   <= ex_value;
      out_next_pc <= ex_next_pc;
      out_illegal <= ex_illegal;
    end
  end

  assign wr_en        = out_valid && out_ready && (out_rd != REG_ZERO);
  assign wr_idx       = out_rd;
  assign wr_data      = out_value;
  assign ret_stage_rd = out_valid ? out_rd : REG_ZERO;

  // decode clears rd for illegal words, so they never reach the regfile
  a_no_bad_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (wr_idx != REG_ZERO) && !out_illegal);

  a_record_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_rd) &&
                                $stable(out_value) && $stable(out_next_pc) &&
                                $stable(out_illegal));

endmodule

/* verilog/int_core_top.sv */
// int_core_top: rv64i subset pipeline, decode, execute and retire around the register file
`timescale 1ns/10ps

module int_core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  rv_core_pkg::addr_t    in_pc,
  input  rv_core_pkg::inst_t    in_inst,
  output logic                  out_valid,
  input  logic                  out_ready,
  output rv_core_pkg::addr_t    out_pc,
  output rv_core_pkg::reg_idx_t out_rd,
  output rv_core_pkg::xlen_t    out_value,
  output rv_core_pkg::addr_t    out_next_pc,
  output logic                  out_illegal
);

  import rv_core_pkg::*;

  reg_idx_t rs1_idx, rs2_idx;
  xlen_t    rs1_val, rs2_val;
  logic     wr_en;
  reg_idx_t wr_idx;
  xlen_t    wr_data;
  reg_idx_t ex_stage_rd, ret_stage_rd;

  logic     dec_valid, dec_ready;
  op_e      dec_op;
  addr_t    dec_pc;
  reg_idx_t dec_rd;
  xlen_t    dec_rs1_val, dec_rs2_val, dec_imm;

  logic     ex_valid, ex_ready;
  addr_t    ex_pc, ex_next_pc;
  reg_idx_t ex_rd;
  xlen_t    ex_value;
  logic     ex_illegal;

  reg_file u_reg_file (
    .clk, .rs1_idx, .rs2_idx, .rs1_val, .rs2_val, .wr_en, .wr_idx, .wr_data
  );

  inst_decoder u_decoder (
    .clk, .rst_n, .in_valid, .in_ready, .in_pc, .in_inst, .ex_stage_rd, .ret_stage_rd,
    .rs1_idx, .rs2_idx, .rs1_val, .rs2_val, .dec_valid, .dec_ready, .dec_op, .dec_pc,
    .dec_rd, .dec_rs1_val, .dec_rs2_val, .dec_imm
  );

  exec_unit u_exec (
    .clk, .rst_n, .dec_valid, .dec_ready, .dec_op, .dec_pc, .dec_rd, .dec_rs1_val,
    .dec_rs2_val, .dec_imm, .ex_valid, .ex_ready, .ex_pc, .ex_rd, .ex_value, .ex_next_pc,
    .ex_illegal, .ex_stage_rd
  );

  retire_stage u_retire (
    .clk, .rst_n, .ex_valid, .ex_ready, .ex_pc, .ex_rd, .ex_value, .ex_next_pc, .ex_illegal,
    .out_valid, .out_ready, .out_pc, .out_rd, .out_value, .out_next_pc, .out_illegal,
    .wr_en, .wr_idx, .wr_data, .ret_stage_rd
  );

endmodule

/* verification/int_core_tb.sv */
// int_core_tb drives the rv64i subset pipeline with directed tests against an in-order model
`timescale 1ns/10ps

module int_core_tb;

  import rv_core_pkg::*;

  localparam int TIMEOUT = 200;  // cycles per wait

  typedef struct packed {
    addr_t    pc;
    reg_idx_t rd;
    xlen_t    value;
    addr_t    next_pc;
    logic     illegal;
  } retire_rec_t;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  logic     in_ready;
  addr_t    in_pc;
  inst_t    in_inst;
  logic     out_valid;
  logic     out_ready;
  addr_t    out_pc;
  reg_idx_t out_rd;
  xlen_t    out_value;
  addr_t    out_next_pc;
  logic     out_illegal;

  retire_rec_t exp_q [$];          // expected records in program order
  xlen_t       model_regs [32];
  addr_t       cur_pc;
  logic [63:0] rnd_state;
  logic [63:0] bp_state;
  logic        bp_enable;
  int          errors;
  int          checks;

  int_core_top dut (
    .clk, .rst_n, .in_valid, .in_ready, .in_pc, .in_inst, .out_valid, .out_ready,
    .out_pc, .out_rd, .out_value, .out_next_pc, .out_illegal
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 7);
    return x ^ (x << 17);
  endfunction

  // instruction format encoders
  function automatic inst_t r_type(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t s_type(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  function automatic inst_t b_type(input logic [12:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // reference model that updates model_regs in program order
  function automatic retire_rec_t predict(input addr_t pc, input inst_t inst);
    retire_rec_t r;
    logic [2:0]  f3;
    xlen_t       a, b, imm_i, imm_b, imm_j, imm_u;
    logic [31:0] w;
    logic        branch;
    f3        = inst[14:12];
    a         = model_regs[inst[19:15]];
    b         = model_regs[inst[24:20]];
    imm_i     = {{52{inst[31]}}, inst[31:20]};
    imm_b     = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j     = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_u     = {{32{inst[31]}}, inst[31:12], 12'd0};
    r.pc      = pc;
    r.rd      = inst[11:7];
    r.value   = '0;
    r.next_pc = pc + 64'd4;
    r.illegal = 1'b0;
    branch    = 1'b0;
    case (inst[6:0])
      OPC_OP: begin
        case ({inst[31:25], f3})
          {F7_BASE, F3_ADD_SUB}: r.value = a + b;
          {F7_ALT, F3_ADD_SUB}:  r.value = a - b;
          {F7_BASE, F3_SLTU}:    r.value = {63'd0, a < b};
          {F7_BASE, F3_AND}:     r.value = a & b;
          default:               r.illegal = 1'b1;
        endcase
      end
      OPC_OP_32: begin
        w         = (f3 == F3_SLL) ? (a[31:0] << b[4:0]) : (a[31:0] + b[31:0]);
        r.value   = {{32{w[31]}}, w};
        r.illegal = (inst[31:25] != F7_BASE) || !(f3 inside {F3_ADD_SUB, F3_SLL});
      end
      OPC_OP_IMM: begin
        case (f3)
          F3_ADD_SUB: r.value = a + imm_i;
          F3_SLTU:    r.value = {63'd0, a < imm_i};
          F3_XOR:     r.value = a ^ imm_i;
          F3_AND:     r.value = a & imm_i;
          F3_SR: begin
            r.value   = xlen_t'($signed(a) >>> inst[25:20]);
            r.illegal = (inst[31:26] != F6_SRA);
          end
          default:    r.illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM_32: begin
        w         = a[31:0] + imm_i[31:0];
        r.value   = {{32{w[31]}}, w};
        r.illegal = (f3 != F3_ADD_SUB);
      end
      OPC_LUI:   r.value = imm_u;
      OPC_AUIPC: r.value = pc + imm_u;
      OPC_JAL: begin
        r.value   = pc + 64'd4;
        r.next_pc = pc + imm_j;
      end
      OPC_JALR: begin
        r.value   = pc + 64'd4;
        r.next_pc = (a + imm_i) & ~64'd1;
        r.illegal = (f3 != F3_JALR);
      end
      OPC_BRANCH: begin
        branch = 1'b1;
        if (f3 == F3_BEQ) begin
          r.next_pc = (a == b) ? pc + imm_b : pc + 64'd4;
        end else if (f3 == F3_BNE) begin
          r.next_pc = (a != b) ? pc + imm_b : pc + 64'd4;
        end else begin
          r.illegal = 1'b1;
        end
      end
      default: r.illegal = 1'b1;  // loads, stores, system
    endcase
    if (r.illegal) begin
      r.value   = '0;
      r.next_pc = pc + 64'd4;
    end
    if (r.illegal || branch) begin
      r.rd = '0;
    end
    if (r.rd != REG_ZERO) begin
      model_regs[r.rd] = r.value;
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s for %0d cycles", what, TIMEOUT);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  // drives one instruction and returns on the edge that transfers it
  task automatic send(input inst_t inst);
    int waited;
    exp_q.push_back(predict(cur_pc, inst));
    #1;
    in_valid = 1'b1;
    in_pc    = cur_pc;
    in_inst  = inst;
    waited   = 0;
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("in_ready stayed low");
      @(negedge clk);
    end
    @(posedge clk);
    cur_pc = cur_pc + 64'd4;
  endtask

  // waits until every expected record has retired
  task automatic drain();
    int waited;
    #1;
    in_valid = 1'b0;
    waited   = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("retire records still missing");
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic report_test(input string name, input int err_start);
    $display("test %s finished with %0d errors", name, errors - err_start);
  endtask

  // records sampled mid-cycle where they are stable before the handshake edge
  always @(negedge clk) begin
    retire_rec_t e;
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("error at %0d ns: a record retired with no instruction outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("out_pc", out_pc, e.pc);
        check_value("out_rd", 64'(out_rd), 64'(e.rd));
        check_value("out_value", out_value, e.value);
        check_value("out_next_pc", out_next_pc, e.next_pc);
        check_value("out_illegal", 64'(out_illegal), 64'(e.illegal));
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (bp_enable) begin
      bp_state  = xorshift(bp_state);
      out_ready = bp_state[7];
    end else begin
      out_ready = 1'b1;
    end
  end

  task automatic arith_dependencies();
    int err_start;
    err_start = errors;
    send(u_type(20'h12345, 5'd1, OPC_LUI));
    send(i_type(12'h678, 5'd1, F3_ADD_SUB, 5'd1, OPC_OP_IMM));
    send(u_type(20'hfedcb, 5'd2, OPC_LUI));
    send(i_type(12'hfff, 5'd2, F3_ADD_SUB, 5'd2, OPC_OP_IMM));  // x2 - 1
    send(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd3, OPC_OP));
    send(r_type(F7_ALT, 5'd1, 5'd3, F3_ADD_SUB, 5'd4, OPC_OP));
    send(r_type(F7_BASE, 5'd3, 5'd4, F3_SLTU, 5'd5, OPC_OP));
    send(r_type(F7_BASE, 5'd4, 5'd2, F3_AND, 5'd6, OPC_OP));
    send(r_type(F7_BASE, 5'd6, 5'd1, F3_ADD_SUB, 5'd7, OPC_OP_32));  // addw
    send(r_type(F7_BASE, 5'd2, 5'd7, F3_SLL, 5'd8, OPC_OP_32));      // sllw by 31
    send(r_type(F7_BASE, 5'd8, 5'd8, F3_ADD_SUB, 5'd9, OPC_OP));
    drain();
    report_test("arith_dependencies", err_start);
  endtask

  task automatic immediate_forms();
    int          err_start;
    logic [11:0] neg;
    err_start = errors;
    for (int i = 0; i < 6; i++) begin
      rnd_state = xorshift(rnd_state);
      neg       = {1'b1, rnd_state[42:32]};
      send(u_type(rnd_state[19:0], 5'd10, OPC_LUI));
      send(i_type(rnd_state[31:20], 5'd10, F3_ADD_SUB, 5'd10, OPC_OP_IMM));
      send(i_type(neg, 5'd10, F3_ADD_SUB, 5'd11, OPC_OP_IMM));
      send(i_type(neg, 5'd10, F3_SLTU, 5'd12, OPC_OP_IMM));
      send(i_type(neg, 5'd10, F3_XOR, 5'd13, OPC_OP_IMM));
      send(i_type(neg, 5'd10, F3_AND, 5'd14, OPC_OP_IMM));
      send(i_type(neg, 5'd11, F3_ADD_SUB, 5'd15, OPC_OP_IMM_32));  // addiw
      send(i_type({F6_SRA, rnd_state[48:43]}, 5'd10, F3_SR, 5'd16, OPC_OP_IMM));
      send(u_type(rnd_state[63:44], 5'd17, OPC_AUIPC));
    end
    drain();
    report_test("immediate_forms", err_start);
  endtask

  task automatic control_transfer();
    int err_start;
    err_start = errors;
    send(i_type(12'd100, 5'd0, F3_ADD_SUB, 5'd1, OPC_OP_IMM));
    send(i_type(12'd100, 5'd0, F3_ADD_SUB, 5'd2, OPC_OP_IMM));
    send(i_type(12'd7, 5'd0, F3_ADD_SUB, 5'd3, OPC_OP_IMM));
    send(j_type(21'h000010, 5'd5));                            // forward 16
    send(j_type(21'h1ffff8, 5'd6));                            // back 8
    send(i_type(12'd5, 5'd1, F3_JALR, 5'd6, OPC_JALR));        // sum 105 is odd
    send(b_type(13'd8, 5'd2, 5'd1, F3_BEQ));                   // taken
    send(b_type(13'd8, 5'd3, 5'd1, F3_BEQ));
    send(b_type(13'h1ff4, 5'd3, 5'd1, F3_BNE));                // taken backward by 12
    send(b_type(13'd8, 5'd2, 5'd1, F3_BNE));
    drain();
    report_test("control_transfer", err_start);
  endtask

  task automatic backpressure_order();
    int err_start;
    err_start = errors;
    bp_enable = 1'b1;
    for (int i = 0; i < 24; i++) begin
      rnd_state = xorshift(rnd_state);
      send(i_type(rnd_state[11:0], 5'd0, i[0] ? F3_XOR : F3_ADD_SUB, 5'(i + 1), OPC_OP_IMM));
    end
    drain();
    bp_enable = 1'b0;
    report_test("backpressure_order", err_start);
  endtask

  task automatic illegal_and_x0();
    int err_start;
    err_start = errors;
    send(i_type(12'd8, 5'd1, 3'b011, 5'd7, OPC_LOAD));          // ld x7
    send(s_type(12'd16, 5'd2, 5'd1, 3'b011, OPC_STORE));        // sd
    send(32'h00100073);                                         // ebreak
    send(i_type(12'd55, 5'd1, F3_ADD_SUB, 5'd0, OPC_OP_IMM));   // addi x0
    drain();                                                    // x0 write attempt retires first
    send(r_type(F7_BASE, 5'd0, 5'd0, F3_ADD_SUB, 5'd9, OPC_OP));
    send(r_type(F7_BASE, 5'd7, 5'd0, F3_ADD_SUB, 5'd10, OPC_OP));  // x7 kept by the load
    drain();
    report_test("illegal_and_x0", err_start);
  endtask

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_pc     = '0;
    in_inst   = '0;
    out_ready = 1'b1;
    bp_enable = 1'b0;
    rnd_state = 64'd41;
    bp_state  = 64'd41;
    cur_pc    = 64'h1000;
    errors    = 0;
    checks    = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (15) @(posedge clk);
    @(negedge clk);
    check_value("in_ready", 64'(in_ready), 64'd1);
    check_value("out_valid", 64'(out_valid), 64'd0);
    @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    arith_dependencies();
    immediate_forms();
    control_transfer();
    backpressure_order();
    illegal_and_x0();
    $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/rv_core_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/exec_unit.sv
verilog/retire_stage.sv
verilog/int_core_top.sv
verification/int_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
TOP       := int_core_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
